/* build.f */
wb_pkg.sv
video_if.sv
frame_stats.sv
gain_calc.sv
pixel_scaler.sv
video_delay.sv
white_balance.sv
wb_assertions.sv
wb_tb.sv

/* frame_stats.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_stats #(
    parameter int  H_ACT = 1280,
    parameter int  V_ACT = 720,
    localparam int SUM_W = 8 + $clog2(H_ACT * V_ACT)
) (
    input  logic             clk,
    input  logic             rstn,
    video_if.snk             i_vid,
    input  logic             i_update,
    output logic [SUM_W-1:0] o_sum_r,
    output logic [SUM_W-1:0] o_sum_g,
    output logic [SUM_W-1:0] o_sum_b,
    output logic             o_sums_valid
);

    logic             vsync_d;
    logic             vs_rise;
    logic [SUM_W-1:0] acc_r;
    logic [SUM_W-1:0] acc_g;
    logic [SUM_W-1:0] acc_b;

    assign vs_rise = i_vid.vsync & ~vsync_d; // Start of the vertical sync pulse

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vsync_d <= 1'b0;
        end else begin
            vsync_d <= i_vid.vsync;
        end
    end

    // Running sums of the frame in progress
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            acc_r <= '0;
            acc_g <= '0;
            acc_b <= '0;
        end else if (vs_rise) begin
            acc_r <= '0;
            acc_g <= '0;
            acc_b <= '0;
        end else if (i_vid.de) begin
            acc_r <= acc_r + SUM_W'(i_vid.r);
            acc_g <= acc_g + SUM_W'(i_vid.g);
            acc_b <= acc_b + SUM_W'(i_vid.b);
        end
    end

    // Held sums only move when the frame ends with update requested
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_sum_r      <= '0;
            o_sum_g      <= '0;
            o_sum_b      <= '0;
            o_sums_valid <= 1'b0;
        end else begin
            o_sums_valid <= vs_rise & i_update;
            if (vs_rise && i_update) begin
                o_sum_r <= acc_r;
                o_sum_g <= acc_g;
                o_sum_b <= acc_b;
            end
        end
    end

endmodule : frame_stats

`default_nettype wire

/* gain_calc.sv */
`timescale 1ns/1ps
`default_nettype none

module gain_calc
    import wb_pkg::*;
#(
    parameter int  H_ACT = 1280,
    parameter int  V_ACT = 720,
    localparam int SUM_W = 8 + $clog2(H_ACT * V_ACT)
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic [SUM_W-1:0]  i_sum_r,
    input  logic [SUM_W-1:0]  i_sum_g,
    input  logic [SUM_W-1:0]  i_sum_b,
    input  logic              i_sums_valid,
    output logic [GAIN_W-1:0] o_gain_r,
    output logic [GAIN_W-1:0] o_gain_g,
    output logic [GAIN_W-1:0] o_gain_b,
    output logic              o_refresh
);

    localparam int PIXELS = H_ACT * V_ACT;
    localparam int DIV_W  = (SUM_W > 8 + GAIN_FRAC) ? SUM_W : 8 + GAIN_FRAC; // Fits avg << 8
    localparam int CNT_W  = $clog2(DIV_W);

    calc_state_t       state;
    calc_state_t       state_nx;
    logic              div_run;
    logic [CNT_W-1:0]  div_cnt;
    logic              div_last;
    logic [DIV_W-1:0]  div_a;
    logic [DIV_W-1:0]  div_b;
    logic [DIV_W-1:0]  quo;
    logic [DIV_W-1:0]  dsr;
    logic [DIV_W-1:0]  rem;
    logic [DIV_W:0]    rem_sh;
    logic [DIV_W:0]    rem_nx;
    logic              sub_ok;
    logic [DIV_W-1:0]  quo_nx;
    logic              zero_div;
    logic              store;
    logic [7:0]        mean_r;
    logic [7:0]        mean_g;
    logic [7:0]        mean_b;
    logic [7:0]        avg;
    logic [7:0]        cur_mean;
    logic [GAIN_W-1:0] gain_sat;
    logic [GAIN_W-1:0] gain_res;
    logic [GAIN_W-1:0] stg_r;
    logic [GAIN_W-1:0] stg_g;
    logic [GAIN_W-1:0] stg_b;

    always_comb begin
        case (state)
            IDLE:    state_nx = MEAN_R;
            MEAN_R:  state_nx = MEAN_G;
            MEAN_G:  state_nx = MEAN_B;
            MEAN_B:  state_nx = AVG;
            AVG:     state_nx = GAIN_R;
            GAIN_R:  state_nx = GAIN_G;
            GAIN_G:  state_nx = GAIN_B;
            GAIN_B:  state_nx = LOAD;
            default: state_nx = IDLE;
        endcase
    end

    assign cur_mean = (state == GAIN_R) ? mean_r : (state == GAIN_G) ? mean_g : mean_b;

    // Operands for the division of the current state
    always_comb begin
        div_a = DIV_W'(avg) << GAIN_FRAC;
        div_b = DIV_W'(cur_mean);
        case (state)
            MEAN_R: begin
                div_a = DIV_W'(i_sum_r);
                div_b = DIV_W'(PIXELS);
            end
            MEAN_G: begin
                div_a = DIV_W'(i_sum_g);
                div_b = DIV_W'(PIXELS);
            end
            MEAN_B: begin
                div_a = DIV_W'(i_sum_b);
                div_b = DIV_W'(PIXELS);
            end
            AVG: begin
                div_a = DIV_W'(mean_r) + DIV_W'(mean_g) + DIV_W'(mean_b);
                div_b = DIV_W'(3);
            end
            default: ;
        endcase
    end

    // One restoring step per cycle, quotient bits shift in where the dividend leaves
    assign rem_sh   = {rem, quo[DIV_W-1]};
    assign sub_ok   = rem_sh >= {1'b0, dsr};
    assign rem_nx   = sub_ok ? rem_sh - {1'b0, dsr} : rem_sh;
    assign quo_nx   = {quo[DIV_W-2:0], sub_ok};
    assign div_last = div_cnt == CNT_W'(DIV_W - 1);

    assign zero_div = div_b == '0; // Only a zero channel mean gets here
    assign store    = div_run ? div_last : zero_div;
    assign gain_sat = (quo_nx > DIV_W'({GAIN_W{1'b1}})) ? {GAIN_W{1'b1}} : quo_nx[GAIN_W-1:0];
    assign gain_res = zero_div ? GAIN_UNITY : gain_sat;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= IDLE;
            div_run   <= 1'b0;
            div_cnt   <= '0;
            o_gain_r  <= GAIN_UNITY;
            o_gain_g  <= GAIN_UNITY;
            o_gain_b  <= GAIN_UNITY;
            o_refresh <= 1'b0;
        end else begin
            o_refresh <= 1'b0;
            case (state)
                IDLE: begin
                    if (i_sums_valid) state <= state_nx; // Strobes while busy are dropped
                end
                LOAD: begin
                    o_gain_r  <= stg_r;
                    o_gain_g  <= stg_g;
                    o_gain_b  <= stg_b;
                    o_refresh <= 1'b1;
                    state     <= state_nx;
                end
                default: begin
                    if (store) begin
                        div_run <= 1'b0;
                        state   <= state_nx;
                    end else if (div_run) begin
                        div_cnt <= div_cnt + 1'b1;
                    end else begin
                        div_run <= 1'b1;
                        div_cnt <= '0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (div_run) begin
            quo <= quo_nx;
            rem <= rem_nx[DIV_W-1:0];
        end else begin
            quo <= div_a;
            dsr <= div_b;
            rem <= '0;
        end
        if (store) begin
            case (state)
                MEAN_R:  mean_r <= quo_nx[7:0];
                MEAN_G:  mean_g <= quo_nx[7:0];
                MEAN_B:  mean_b <= quo_nx[7:0];
                AVG:     avg    <= quo_nx[7:0];
                GAIN_R:  stg_r  <= gain_res;
                GAIN_G:  stg_g  <= gain_res;
                GAIN_B:  stg_b  <= gain_res;
                default: ;
            endcase
        end
    end

endmodule : gain_calc

`default_nettype wire

/* pixel_scaler.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_scaler
    import wb_pkg::*;
(
    input  logic              clk,
    video_if.snk              i_vid,
    input  logic [GAIN_W-1:0] i_gain_r,
    input  logic [GAIN_W-1:0] i_gain_g,
    input  logic [GAIN_W-1:0] i_gain_b,
    output logic [7:0]        o_r,
    output logic [7:0]        o_g,
    output logic [7:0]        o_b
);

    localparam int PROD_W = 8 + GAIN_W;

    // Channel 2 is red, 1 is green, 0 is blue
    logic [2:0][7:0]        pix;
    logic [2:0][GAIN_W-1:0] gain;
    logic [2:0][PROD_W-1:0] prod;
    logic [2:0][7:0]        clamped;
    logic [2:0][7:0]        out_q [PIPE_LAT-1];

    assign pix  = {i_vid.r, i_vid.g, i_vid.b};
    assign gain = {i_gain_r, i_gain_g, i_gain_b};

    // First stage holds the full products
    always_ff @(posedge clk) begin
        for (int c = 0; c < 3; c++) begin
            prod[c] <= PROD_W'(pix[c]) * PROD_W'(gain[c]);
        end
    end

    // Drop the fraction and saturate at full scale
    always_comb begin
        for (int c = 0; c < 3; c++) begin
            if (|prod[c][PROD_W-1:GAIN_FRAC+8]) begin
                clamped[c] = 8'hFF;
            end else begin
                clamped[c] = prod[c][GAIN_FRAC+7:GAIN_FRAC];
            end
        end
    end

    // Remaining stages up to the fixed pipeline latency
    always_ff @(posedge clk) begin
        out_q[0] <= clamped;
        for (int i = 1; i < PIPE_LAT - 1; i++) begin
            out_q[i] <= out_q[i-1];
        end
    end

    assign {o_r, o_g, o_b} = out_q[PIPE_LAT-2];

endmodule : pixel_scaler

`default_nettype wire

/* video_delay.sv */
`timescale 1ns/1ps
`default_nettype none

module video_delay
    import wb_pkg::*;
#(
    parameter int  H_ACT = 1280,
    parameter int  V_ACT = 720,
    localparam int X_W   = $clog2(H_ACT),
    localparam int Y_W   = $clog2(V_ACT)
) (
    input  logic clk,
    input  logic rstn,
    video_if.snk i_vid,
    video_if.src o_vid
);

    localparam int DAT_W = 24 + X_W + Y_W;

    logic [2:0]       ctl_q [PIPE_LAT]; // hsync, vsync, de
    logic [DAT_W-1:0] dat_q [PIPE_LAT];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ctl_q <= '{default: '0};
        end else begin
            ctl_q[0] <= {i_vid.hsync, i_vid.vsync, i_vid.de};
            for (int i = 1; i < PIPE_LAT; i++) ctl_q[i] <= ctl_q[i-1];
        end
    end

    always_ff @(posedge clk) begin
        dat_q[0] <= {i_vid.r, i_vid.g, i_vid.b, i_vid.x, i_vid.y};
        for (int i = 1; i < PIPE_LAT; i++) dat_q[i] <= dat_q[i-1];
    end

    assign {o_vid.hsync, o_vid.vsync, o_vid.de} = ctl_q[PIPE_LAT-1];
    assign {o_vid.r, o_vid.g, o_vid.b, o_vid.x, o_vid.y} = dat_q[PIPE_LAT-1];

endmodule : video_delay

`default_nettype wire

/* video_if.sv */
`timescale 1ns/1ps
`default_nettype none

// One parallel RGB video stream with its sync and coordinates
interface video_if #(
    parameter int X_W = 11,
    parameter int Y_W = 10
);

    logic           hsync;
    logic           vsync;
    logic           de;
    logic [7:0]     r;
    logic [7:0]     g;
    logic [7:0]     b;
    logic [X_W-1:0] x;
    logic [Y_W-1:0] y;

    modport src (
        output hsync, vsync, de,
        output r, g, b,
        output x, y
    );

    modport snk (
        input hsync, vsync, de,
        input r, g, b,
        input x, y
    );

endinterface : video_if

`default_nettype wire

/* wb_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_assertions
    import wb_pkg::*;
(
    input logic        clk,
    input logic        rstn,
    input logic        i_de,
    input logic        o_de,
    input logic        o_hsync,
    input logic        o_vsync,
    input logic        o_refresh,
    input calc_state_t calc_state
);

    // New gains are announced with a single cycle pulse
    refresh_single: assert property (@(posedge clk) disable iff (!rstn)
        o_refresh |=> !o_refresh)
        else $error("o_refresh stayed high for more than one cycle");

    // The engine finishes inside vertical blanking and is idle during active video
    engine_idle: assert property (@(posedge clk) disable iff (!rstn)
        i_de |-> calc_state == IDLE)
        else $error("gain engine still busy during active video");

    de_latency: assert property (@(posedge clk) disable iff (!rstn)
        o_de == $past(i_de, PIPE_LAT))
        else $error("o_de is not i_de delayed by the pipeline latency");

    // First edge after release still shows the reset values
    reset_low: assert property (@(posedge clk)
        $rose(rstn) |-> !o_refresh && !o_hsync && !o_vsync && !o_de)
        else $error("outputs not low coming out of reset");

endmodule : wb_assertions

bind white_balance wb_assertions u_wb_assertions (
    .clk       (clk),
    .rstn      (rstn),
    .i_de      (i_de),
    .o_de      (o_de),
    .o_hsync   (o_hsync),
    .o_vsync   (o_vsync),
    .o_refresh (o_refresh),
    .calc_state(u_gain_calc.state)
);

`default_nettype wire

/* wb_pkg.sv */
`default_nettype none

package wb_pkg;

    // Cycles from an input pixel to the matching output pixel
    localparam int PIPE_LAT = 2;

    // Gains are unsigned 8.8 fixed point
    localparam int GAIN_W    = 16;
    localparam int GAIN_FRAC = 8;

    localparam logic [GAIN_W-1:0] GAIN_UNITY = GAIN_W'(1 << GAIN_FRAC); // Gain of 1.0

    // States of the gain engine, one per division plus the final load
    typedef enum logic [3:0] {
        IDLE,
        MEAN_R,     // sum_r / PIXELS
        MEAN_G,
        MEAN_B,
        AVG,        // (mean_r + mean_g + mean_b) / 3
        GAIN_R,     // (avg << 8) / mean_r
        GAIN_G,
        GAIN_B,
        LOAD        // Publish the staged gains together
    } calc_state_t;

endpackage : wb_pkg

`default_nettype wire

/* wb_stimulus.txt */
// update en base_r base_g base_b jitter_mask gain_r gain_g gain_b (hex)
// Gains are the 8.8 gains in effect for the frame that follows the line's frame
0 1 40 60 80 0F 0100 0100 0100
1 1 40 80 60 00 0180 00C0 0100
0 1 30 50 70 07 0180 00C0 0100
1 1 C8 64 32 00 0094 0128 0251
0 1 F0 F0 F0 0F 0094 0128 0251
0 0 12 34 56 30 0094 0128 0251
1 0 00 00 00 00 0100 0100 0100
1 1 80 80 80 00 0100 0100 0100
1 1 00 40 80 00 0100 0100 0080
0 1 20 40 80 03 0100 0100 0080

/* wb_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_tb
    import wb_pkg::*;
();

    localparam int H_ACT      = 8;
    localparam int V_ACT      = 4;
    localparam int PIXELS     = H_ACT * V_ACT;
    localparam int X_W        = $clog2(H_ACT);
    localparam int Y_W        = $clog2(V_ACT);
    localparam int NUM_FRAMES = 10;
    localparam int FIELDS     = 9;   // Words per line of the stimulus file
    localparam int H_BLANK    = 4;
    localparam int V_SYNC     = 4;
    localparam int V_BLANK    = 400;
    localparam int MAX_CYCLES = NUM_FRAMES * (PIXELS + 450) + 100;

    typedef struct packed {
        logic           hsync;
        logic           vsync;
        logic           de;
        logic [7:0]     r;
        logic [7:0]     g;
        logic [7:0]     b;
        logic [X_W-1:0] x;
        logic [Y_W-1:0] y;
    } beat_t;

    logic           clk;
    logic           rstn;
    logic           i_en;
    logic           i_update;
    logic           i_hsync;
    logic           i_vsync;
    logic           i_de;
    logic [7:0]     i_r;
    logic [7:0]     i_g;
    logic [7:0]     i_b;
    logic [X_W-1:0] i_x;
    logic [Y_W-1:0] i_y;
    logic           o_hsync;
    logic           o_vsync;
    logic           o_de;
    logic [7:0]     o_r;
    logic [7:0]     o_g;
    logic [7:0]     o_b;
    logic [X_W-1:0] o_x;
    logic [Y_W-1:0] o_y;
    logic           o_refresh;

    logic [15:0]       stim [NUM_FRAMES*FIELDS];
    logic [GAIN_W-1:0] model_gain [3];
    logic [31:0]       lfsr;
    logic              frame_en;
    logic              frame_update;
    beat_t             exp_q [$];
    int                check_count = 0;
    int                err_count = 0;
    int                refresh_count = 0;
    int                cycle_count = 0;

    white_balance #(.H_ACT(H_ACT), .V_ACT(V_ACT)) u_white_balance (
        .clk      (clk),
        .rstn     (rstn),
        .i_en     (i_en),
        .i_update (i_update),
        .i_hsync  (i_hsync),
        .i_vsync  (i_vsync),
        .i_de     (i_de),
        .i_r      (i_r),
        .i_g      (i_g),
        .i_b      (i_b),
        .i_x      (i_x),
        .i_y      (i_y),
        .o_hsync  (o_hsync),
        .o_vsync  (o_vsync),
        .o_de     (o_de),
        .o_r      (o_r),
        .o_g      (o_g),
        .o_b      (o_b),
        .o_x      (o_x),
        .o_y      (o_y),
        .o_refresh(o_refresh)
    );

    always #5 clk = ~clk;

    // Galois LFSR with taps at bits 32 22 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end else begin
            return s >> 1;
        end
    endfunction

    // Pixel times the 8.8 gain with the fraction dropped and the result limited to full scale
    function automatic logic [7:0] corrected_value(input logic [7:0] pix,
                                                   input logic [GAIN_W-1:0] gain,
                                                   input logic en);
        int scaled;
        scaled = (int'(pix) * int'(gain)) >> 8;
        if (!en) begin
            return pix;
        end
        if (scaled > 255) begin
            scaled = 255;
        end
        return scaled[7:0];
    endfunction

    task automatic jitter_colour(input logic [7:0] base, input logic [7:0] mask,
                                 output logic [7:0] val);
        val = base;
        for (int i = 0; i < 8; i++) begin
            if (mask[i]) begin
                val[i] = base[i] ^ lfsr[0]; // One LFSR step per bit taken
                lfsr   = lfsr_next(lfsr);
            end
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        check_count++;
        if (got !== want) begin
            err_count++;
            $display("Error %s got 0x%0h expected 0x%0h at %0t", name, got, want, $time);
        end
    endtask

    task automatic drive_beat(input logic hs, input logic vs, input logic de,
                              input logic [7:0] r, input logic [7:0] g, input logic [7:0] b,
                              input logic [X_W-1:0] x, input logic [Y_W-1:0] y);
        beat_t beat;
        @(posedge clk);
        i_en     <= frame_en;
        i_update <= frame_update;
        i_hsync  <= hs;
        i_vsync  <= vs;
        i_de     <= de;
        i_r      <= r;
        i_g      <= g;
        i_b      <= b;
        i_x      <= x;
        i_y      <= y;
        beat.hsync = hs;
        beat.vsync = vs;
        beat.de    = de;
        beat.r     = corrected_value(r, model_gain[0], frame_en);
        beat.g     = corrected_value(g, model_gain[1], frame_en);
        beat.b     = corrected_value(b, model_gain[2], frame_en);
        beat.x     = x;
        beat.y     = y;
        exp_q.push_back(beat);
    endtask

    task automatic run_frame(input int f);
        logic [7:0] base [3];
        logic [7:0] pix [3];
        logic [7:0] mask;
        int         sums [3];
        int         means [3];
        int         avg;
        int         gain;
        int         errs_before;
        errs_before  = err_count;
        frame_update = stim[f*FIELDS][0];
        frame_en     = stim[f*FIELDS+1][0];
        mask         = stim[f*FIELDS+5][7:0];
        for (int c = 0; c < 3; c++) begin
            base[c] = stim[f*FIELDS+2+c][7:0];
            sums[c] = 0;
        end
        refresh_count = 0;

        for (int y = 0; y < V_ACT; y++) begin
            for (int x = 0; x < H_ACT; x++) begin
                for (int c = 0; c < 3; c++) begin
                    jitter_colour(base[c], mask, pix[c]);
                    sums[c] += pix[c];
                end
                drive_beat(1'b0, 1'b0, 1'b1, pix[0], pix[1], pix[2], X_W'(x), Y_W'(y));
            end
            for (int h = 0; h < H_BLANK; h++) begin
                drive_beat(h == 1 || h == 2, 1'b0, 1'b0, 8'h00, 8'h00, 8'h00, '0, '0);
            end
        end
        for (int v = 0; v < V_SYNC; v++) begin
            drive_beat(1'b0, 1'b1, 1'b0, 8'h00, 8'h00, 8'h00, '0, '0);
        end
        for (int v = 0; v < V_BLANK; v++) begin
            drive_beat(1'b0, 1'b0, 1'b0, 8'h00, 8'h00, 8'h00, '0, '0);
        end

        check_value("o_refresh pulse count", refresh_count, frame_update ? 1 : 0);

        // The following frame sees the gray-world gains worked out here
        if (frame_update) begin
            for (int c = 0; c < 3; c++) begin
                means[c] = sums[c] / PIXELS;
            end
            avg = (means[0] + means[1] + means[2]) / 3;
            for (int c = 0; c < 3; c++) begin
                if (means[c] == 0) begin
                    model_gain[c] = GAIN_UNITY;
                end else begin
                    gain = (avg * 256) / means[c];
                    if (gain > 65535) begin
                        gain = 65535;
                    end
                    model_gain[c] = gain[15:0];
                end
            end
        end
        for (int c = 0; c < 3; c++) begin
            check_value($sformatf("model gain %0d vs file", c), model_gain[c],
                        stim[f*FIELDS+6+c]);
        end

        $display("Frame %0d update %0d en %0d: %0d errors", f, frame_update, frame_en,
                 err_count - errs_before);
    endtask

    // Outputs are compared at the falling edge PIPE_LAT beats after they were driven
    always @(negedge clk) begin
        beat_t want;
        if (rstn && o_refresh === 1'b1) begin
            refresh_count++;
        end
        if (exp_q.size() > PIPE_LAT) begin
            want = exp_q.pop_front();
            check_value("o_hsync", o_hsync, want.hsync);
            check_value("o_vsync", o_vsync, want.vsync);
            check_value("o_de", o_de, want.de);
            check_value("o_r", o_r, want.r);
            check_value("o_g", o_g, want.g);
            check_value("o_b", o_b, want.b);
            check_value("o_x", o_x, want.x);
            check_value("o_y", o_y, want.y);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Error: simulation did not finish within %0d cycles", MAX_CYCLES);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        clk          = 1'b0;
        rstn         = 1'b0;
        i_en         = 1'b0;
        i_update     = 1'b0;
        i_hsync      = 1'b0;
        i_vsync      = 1'b0;
        i_de         = 1'b0;
        i_r          = 8'h00;
        i_g          = 8'h00;
        i_b          = 8'h00;
        i_x          = '0;
        i_y          = '0;
        frame_en     = 1'b0;
        frame_update = 1'b0;
        lfsr         = 32'd81408;
        for (int c = 0; c < 3; c++) begin
            model_gain[c] = GAIN_UNITY;
        end
        $readmemh("wb_stimulus.txt", stim);
        if ($isunknown(stim[NUM_FRAMES*FIELDS-1])) begin
            err_count++;
            $display("Error: the stimulus file wb_stimulus.txt is missing or too short");
        end

        repeat (4) @(posedge clk);
        rstn <= 1'b1;

        for (int f = 0; f < NUM_FRAMES; f++) begin
            run_frame(f);
        end
        frame_en = 1'b0;
        repeat (PIPE_LAT + 1) begin
            drive_beat(1'b0, 1'b0, 1'b0, 8'h00, 8'h00, 8'h00, '0, '0);
        end
        @(posedge clk);

        $display("Checks %0d, errors %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule : wb_tb

`default_nettype wire

/* white_balance.sv */
`timescale 1ns/1ps
`default_nettype none

module white_balance
    import wb_pkg::*;
#(
    parameter int  H_ACT = 1280,
    parameter int  V_ACT = 720,
    localparam int X_W   = $clog2(H_ACT),
    localparam int Y_W   = $clog2(V_ACT),
    localparam int SUM_W = 8 + $clog2(H_ACT * V_ACT)
) (
    input  logic           clk,
    input  logic           rstn,
    input  logic           i_en,
    input  logic           i_update,
    input  logic           i_hsync,
    input  logic           i_vsync,
    input  logic           i_de,
    input  logic [7:0]     i_r,
    input  logic [7:0]     i_g,
    input  logic [7:0]     i_b,
    input  logic [X_W-1:0] i_x,
    input  logic [Y_W-1:0] i_y,
    output logic           o_hsync,
    output logic           o_vsync,
    output logic           o_de,
    output logic [7:0]     o_r,
    output logic [7:0]     o_g,
    output logic [7:0]     o_b,
    output logic [X_W-1:0] o_x,
    output logic [Y_W-1:0] o_y,
    output logic           o_refresh
);

    logic [SUM_W-1:0]    sum_r;
    logic [SUM_W-1:0]    sum_g;
    logic [SUM_W-1:0]    sum_b;
    logic                sums_valid;
    logic [GAIN_W-1:0]   gain_r;
    logic [GAIN_W-1:0]   gain_g;
    logic [GAIN_W-1:0]   gain_b;
    logic [7:0]          scl_r;
    logic [7:0]          scl_g;
    logic [7:0]          scl_b;
    logic [PIPE_LAT-1:0] en_q;

    video_if #(.X_W(X_W), .Y_W(Y_W)) vid_in ();
    video_if #(.X_W(X_W), .Y_W(Y_W)) vid_out ();

    assign vid_in.hsync = i_hsync;
    assign vid_in.vsync = i_vsync;
    assign vid_in.de    = i_de;
    assign vid_in.r     = i_r;
    assign vid_in.g     = i_g;
    assign vid_in.b     = i_b;
    assign vid_in.x     = i_x;
    assign vid_in.y     = i_y;

    frame_stats #(.H_ACT(H_ACT), .V_ACT(V_ACT)) u_frame_stats (
        .clk         (clk),
        .rstn        (rstn),
        .i_vid       (vid_in.snk),
        .i_update    (i_update),
        .o_sum_r     (sum_r),
        .o_sum_g     (sum_g),
        .o_sum_b     (sum_b),
        .o_sums_valid(sums_valid)
    );

    gain_calc #(.H_ACT(H_ACT), .V_ACT(V_ACT)) u_gain_calc (
        .clk         (clk),
        .rstn        (rstn),
        .i_sum_r     (sum_r),
        .i_sum_g     (sum_g),
        .i_sum_b     (sum_b),
        .i_sums_valid(sums_valid),
        .o_gain_r    (gain_r),
        .o_gain_g    (gain_g),
        .o_gain_b    (gain_b),
        .o_refresh   (o_refresh)
    );

    pixel_scaler u_pixel_scaler (
        .clk     (clk),
        .i_vid   (vid_in.snk),
        .i_gain_r(gain_r),
        .i_gain_g(gain_g),
        .i_gain_b(gain_b),
        .o_r     (scl_r),
        .o_g     (scl_g),
        .o_b     (scl_b)
    );

    video_delay #(.H_ACT(H_ACT), .V_ACT(V_ACT)) u_video_delay (
        .clk  (clk),
        .rstn (rstn),
        .i_vid(vid_in.snk),
        .o_vid(vid_out.src)
    );

    // The enable follows its pixel down the pipeline
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            en_q <= '0;
        end else begin
            en_q <= {en_q[PIPE_LAT-2:0], i_en};
        end
    end

    assign o_hsync = vid_out.hsync;
    assign o_vsync = vid_out.vsync;
    assign o_de    = vid_out.de;
    assign o_x     = vid_out.x;
    assign o_y     = vid_out.y;
    assign o_r     = en_q[PIPE_LAT-1] ? scl_r : vid_out.r;
    assign o_g     = en_q[PIPE_LAT-1] ? scl_g : vid_out.g;
    assign o_b     = en_q[PIPE_LAT-1] ? scl_b : vid_out.b;

endmodule : white_balance

`default_nettype wire
